/* Bender.yml */
package:
  name: zknh_sched

sources:
  - files:
      - hw/zknhPkg.sv
      - hw/sha512Half.sv
      - hw/zknhSeqFsm.sv
      - hw/windowPtrCounter.sv
      - hw/scheduleWindow.sv
      - hw/sigmaAccum.sv
      - hw/zknhSchedTop.sv
  - target: simulation
    files:
      - bench/zknhSched_sva.sv
      - bench/zknhSchedTb.sv

/* bench/zknhSchedTb.sv */
`timescale 1ns/1ps

module zknhSchedTb import zknhPkg::*; ();

   // two resets, 32 loads, 70 expands at about 7 cycles and 33 sums at about
   // 5 cycles come to roughly 720 cycles, so 3000 leaves a wide margin
   localparam int MAX_CYCLES = 3000;
   // expand is 5 cycles from start to done
   localparam int DONE_WAIT  = 20;

   logic     clk;
   logic     rstN;
   logic     loadValid;
   fullWordT loadWord;
   logic     start;
   cmdT      cmd;
   fullWordT sumOperand;
   logic     busy;
   logic     done;
   fullWordT result;
   wordIdxT  wordIndex;

   // every schedule word since reset, W[0] first
   fullWordT    model[$];
   // expected results, oldest first
   fullWordT    expQ[$];
   fullWordT    expWord;
   fullWordT    operand;
   fullWordT    corners[6];
   int          wordCount;
   int          checks;
   int          errors;
   int          testErrors;
   int          cycles = 0;

   zknhSchedTop #(.WINDOW_DEPTH(16)) zknhSchedTop_inst (
      .clk, .rstN, .loadValid, .loadWord, .start, .cmd, .sumOperand,
      .busy, .done, .result, .wordIndex
   );

   //////////////////////////////////////////////////////////////////////
   // clock and run limit
   //////////////////////////////////////////////////////////////////////

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("run timed out after %0d cycles", cycles);
         $display("*** FAILED ***");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // reference model, plain 64-bit rotates
   //////////////////////////////////////////////////////////////////////

   function automatic fullWordT rotr(input fullWordT x, input int n);
      return (x >> n) | (x << (64 - n));
   endfunction

   function automatic fullWordT refSig0(input fullWordT x);
      return rotr(x, 1) ^ rotr(x, 8) ^ (x >> 7);
   endfunction

   function automatic fullWordT refSig1(input fullWordT x);
      return rotr(x, 19) ^ rotr(x, 61) ^ (x >> 6);
   endfunction

   // expected result of one command against the model window
   function automatic fullWordT refResult(input cmdT c, input fullWordT op);
      int n;
      n = model.size();
      case (c)
         cmdSum0: return rotr(op, 28) ^ rotr(op, 34) ^ rotr(op, 39);
         cmdSum1: return rotr(op, 14) ^ rotr(op, 18) ^ rotr(op, 41);
         // W[t] recurrence, wraps mod 2^64
         default: return refSig1(model[n-2]) + model[n-7] + refSig0(model[n-15])
                         + model[n-16];
      endcase
   endfunction

   //////////////////////////////////////////////////////////////////////
   // stimulus tasks, all called at a falling edge
   //////////////////////////////////////////////////////////////////////

   task automatic resetDut();
      rstN = 1'b0;
      repeat (8) @(negedge clk);
      rstN = 1'b1;
      model.delete();
      expQ.delete();
      wordCount = 0;
   endtask

   task automatic loadOne(input fullWordT w);
      loadValid = 1'b1;
      loadWord  = w;
      @(negedge clk);
      loadValid = 1'b0;
      model.push_back(w);
      wordCount++;
   endtask

   // queue the expectation, then one start pulse
   task automatic launchCmd(input cmdT c, input fullWordT op);
      fullWordT w;
      w = refResult(c, op);
      expQ.push_back(w);
      // expanded word lands in the window too
      if (c == cmdExpand) begin
         model.push_back(w);
         wordCount++;
      end
      cmd        = c;
      sumOperand = op;
      start      = 1'b1;
      @(negedge clk);
      start = 1'b0;
   endtask

   task automatic waitDone();
      int n;
      n = 0;
      while (!done && n < DONE_WAIT) begin
         @(negedge clk);
         n++;
      end
      if (!done) begin
         errors++;
         $display("no done within %0d cycles of start, at %0t", DONE_WAIT, $time);
         expQ.delete();
      end
      // compare process sees this done before we move on
      @(negedge clk);
   endtask

   task automatic checkIndex();
      wordIdxT expIdx;
      // saturates at W[79]
      expIdx = (wordCount > 79) ? 7'd79 : wordIdxT'(wordCount);
      checks++;
      if (wordIndex !== expIdx) begin
         errors++;
         $display("[FAIL] %0t: wordIndex %0d, expected %0d", $time, wordIndex, expIdx);
      end
   endtask

   task automatic issueCmd(input cmdT c, input fullWordT op);
      launchCmd(c, op);
      waitDone();
      checkIndex();
   endtask

   task automatic reportTest(input string name);
      if (errors == testErrors) $display("test %s: ok", name);
      else $display("test %s: %0d errors", name, errors - testErrors);
   endtask

   //////////////////////////////////////////////////////////////////////
   // compare at each done
   //////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      if (rstN && done) begin
         if (expQ.size() == 0) begin
            errors++;
            $display("done pulsed with no command pending, at %0t", $time);
         end else begin
            expWord = expQ.pop_front();
            checks++;
            if (result !== expWord) begin
               errors++;
               $display("[FAIL] %0t: result %h, expected %h", $time, result, expWord);
            end
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(32'h41fdaf3f));
      rstN       = 1'b0;
      loadValid  = 1'b0;
      loadWord   = '0;
      start      = 1'b0;
      cmd        = cmdExpand;
      sumOperand = '0;
      checks     = 0;
      errors     = 0;
      wordCount  = 0;
      resetDut();

      // idle outputs, then expand on an empty window
      testErrors = errors;
      checks++;
      if (busy || done || result !== '0 || wordIndex !== '0) begin
         errors++;
         $display("[FAIL] %0t: outputs not zero after reset", $time);
      end
      cmd   = cmdExpand;
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      repeat (10) begin
         @(negedge clk);
         if (done || busy) begin
            errors++;
            $display("[FAIL] %0t: expand started on a partial window", $time);
         end
      end
      checkIndex();
      reportTest("reset and early expand");

      // sum0r and sum1r, corners then random
      testErrors = errors;
      corners = '{64'h0, 64'hffff_ffff_ffff_ffff, 64'h1, 64'h8000_0000,
                  64'h1_0000_0000, 64'h8000_0000_0000_0000};
      foreach (corners[i]) begin
         issueCmd(cmdSum0, corners[i]);
         issueCmd(cmdSum1, corners[i]);
      end
      repeat (10) begin
         operand = {$urandom, $urandom};
         issueCmd(cmdSum0, operand);
         issueCmd(cmdSum1, operand);
      end
      reportTest("big sigma");

      // full schedule W[16] .. W[79], index saturates on the last one
      testErrors = errors;
      repeat (16) loadOne({$urandom, $urandom});
      repeat (64) issueCmd(cmdExpand, '0);
      reportTest("random schedule");

      // "abc" padded block
      testErrors = errors;
      resetDut();
      loadOne(64'h6162_6380_0000_0000);
      repeat (14) loadOne(64'h0);
      // message length in bits
      loadOne(64'h18);
      repeat (4) issueCmd(cmdExpand, '0);
      reportTest("abc block");

      // stray start and load while busy
      testErrors = errors;
      launchCmd(cmdExpand, '0);
      @(negedge clk);
      if (!busy) begin
         errors++;
         $display("busy low in the middle of an expand, at %0t", $time);
      end
      start     = 1'b1;
      cmd       = cmdSum1;
      loadValid = 1'b1;
      loadWord  = {$urandom, $urandom};
      @(negedge clk);
      start     = 1'b0;
      loadValid = 1'b0;
      waitDone();
      checkIndex();
      launchCmd(cmdSum0, {$urandom, $urandom});
      loadValid = 1'b1;
      loadWord  = {$urandom, $urandom};
      @(negedge clk);
      loadValid = 1'b0;
      waitDone();
      checkIndex();
      // window must be untouched by the dropped loads
      issueCmd(cmdExpand, '0);
      reportTest("ignored while busy");

      if (zknhSchedTop_inst.sva_inst.failCount != 0) begin
         errors += zknhSchedTop_inst.sva_inst.failCount;
         $display("%0d assertion failures in the bound checker",
                  zknhSchedTop_inst.sva_inst.failCount);
      end

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

/* bench/zknhSched_sva.sv */
`timescale 1ns/1ps

module zknhSchedSva import zknhPkg::*; (
   input logic     clk,
   input logic     rstN,
   input logic     start,
   input cmdT      cmd,
   input logic     windowReady,
   input seqStateT seqState,
   input logic     busy,
   input logic     done
);

   logic acceptExpand;
   logic acceptSum;
   // failed assertions so far
   int   failCount = 0;

   // same accept rule as the sequencer, seen from outside
   assign acceptExpand = start && (seqState == stIdle) && (cmd == cmdExpand) && windowReady;
   assign acceptSum    = start && (seqState == stIdle) &&
                         ((cmd == cmdSum0) || (cmd == cmdSum1));

   resetIdle: assert property (@(posedge clk) !rstN |=> (!busy && !done))
      else begin
         failCount++;
         $error("busy or done high after reset");
      end

   donePulse: assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
      else begin
         failCount++;
         $error("done held longer than one cycle");
      end

   // four passes plus write-back, done in the cycle after
   expandLatency: assert property (@(posedge clk) disable iff (!rstN)
      acceptExpand |=> !done [*5] ##1 done)
      else begin
         failCount++;
         $error("expand done not 5 cycles after start edge");
      end

   sumLatency: assert property (@(posedge clk) disable iff (!rstN)
      acceptSum |=> !done [*3] ##1 done)
      else begin
         failCount++;
         $error("sum done not 3 cycles after start edge");
      end

endmodule

bind zknhSchedTop zknhSchedSva sva_inst (
   .clk, .rstN, .start, .cmd, .windowReady, .seqState, .busy, .done
);

/* hw/scheduleWindow.sv */
`timescale 1ns/1ps

module scheduleWindow import zknhPkg::*; #(
   parameter  int WINDOW_DEPTH = 16,
   localparam int PTR_W        = $clog2(WINDOW_DEPTH)
) (
   input  logic             clk,
   input  logic             loadValid,
   input  logic             busy,
   input  fullWordT         loadWord,
   input  logic             writeNew,
   input  fullWordT         newWord,
   input  logic [PTR_W-1:0] ptr,
   output fullWordT         tapM16,
   output fullWordT         tapM15,
   output fullWordT         tapM7,
   output fullWordT         tapM2
);

   // tap offsets from the oldest slot
   localparam int unsigned OFF_M15 = 1;
   localparam int unsigned OFF_M7  = WINDOW_DEPTH - 7;
   localparam int unsigned OFF_M2  = WINDOW_DEPTH - 2;

   fullWordT mem [WINDOW_DEPTH];

   // ptr plus offset, wrapped at depth
   function automatic logic [PTR_W-1:0] tapIdx(input logic [PTR_W-1:0] base,
                                                input int unsigned      off);
      int unsigned sum;
      sum = int'(base) + off;
      // base and off are both below depth, one subtract is enough
      if (sum >= WINDOW_DEPTH) sum = sum - WINDOW_DEPTH;
      return PTR_W'(sum);
   endfunction

   //////////////////////////////////////////////////////////////////////
   // write port
   //////////////////////////////////////////////////////////////////////

   // ptr always addresses the oldest word, overwritten next
   always_ff @(posedge clk) begin
      if (writeNew) begin
         mem[ptr] <= newWord;
      end else if (loadValid && !busy) begin
         mem[ptr] <= loadWord;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // read taps for W[t-16], W[t-15], W[t-7], W[t-2]
   //////////////////////////////////////////////////////////////////////

   assign tapM16 = mem[ptr];
   assign tapM15 = mem[tapIdx(ptr, OFF_M15)];
   assign tapM7  = mem[tapIdx(ptr, OFF_M7)];
   assign tapM2  = mem[tapIdx(ptr, OFF_M2)];

endmodule

/* hw/sha512Half.sv */
`timescale 1ns/1ps

module sha512Half import zknhPkg::*; (
   input  halfWordT A,
   input  halfWordT B,
   input  halfOpT   ZKNHSelect,
   output halfWordT result
);

   // six shifted operands feeding the xor6
   halfWordT t0, t1, t2, t3, t4, t5;

   //////////////////////////////////////////////////////////////////////
   // operand select per half-op
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      // unused slots and unused encodings stay zero
      t0 = '0;
      t1 = '0;
      t2 = '0;
      t3 = '0;
      t4 = '0;
      t5 = '0;
      case (ZKNHSelect)
         opSig0h, opSig0l: begin
            // rotr1, shr7, rotr8
            t0 = A >> 1;
            t1 = A >> 7;
            t2 = A >> 8;
            t3 = B << 31;
            t4 = B << 24;
            // shr7 spills into the low word only
            if (ZKNHSelect == opSig0l) t5 = B << 25;
         end
         opSig1h, opSig1l: begin
            // rotr19, rotr61, shr6
            t0 = A << 3;
            t1 = A >> 6;
            t2 = A >> 19;
            t3 = B >> 29;
            t4 = B << 13;
            // shr6 spill, low word only
            if (ZKNHSelect == opSig1l) t5 = B << 26;
         end
         opSum0r: begin
            // rotr28, rotr34, rotr39
            t0 = A << 25;
            t1 = A << 30;
            t2 = A >> 28;
            t3 = B >> 7;
            t4 = B >> 2;
            t5 = B << 4;
         end
         opSum1r: begin
            // rotr14, rotr18, rotr41
            t0 = A << 23;
            t1 = A >> 14;
            t2 = A >> 18;
            t3 = B >> 9;
            t4 = B << 18;
            t5 = B << 14;
         end
         default: ;
      endcase
   end

   // xor6
   assign result = t0 ^ t1 ^ t2 ^ t3 ^ t4 ^ t5;

endmodule

/* hw/sigmaAccum.sv */
`timescale 1ns/1ps

module sigmaAccum import zknhPkg::*; (
   input  logic     clk,
   input  logic     rstN,
   input  seqStateT state,
   input  fullWordT tapM15,
   input  fullWordT tapM2,
   input  fullWordT tapM7,
   input  fullWordT tapM16,
   input  fullWordT sumOperand,
   input  halfWordT halfResult,
   input  logic     swapHalves,
   input  logic     capHi,
   input  logic     capLo,
   input  logic     finish,
   output halfWordT opA,
   output halfWordT opB,
   output fullWordT newWord,
   output fullWordT result
);

   fullWordT sumOpQ;
   fullWordT srcWord;
   fullWordT sig1Q;
   fullWordT sig0Q;
   fullWordT sumQ;
   logic     sumMode;

   //////////////////////////////////////////////////////////////////////
   // operand source and half split
   //////////////////////////////////////////////////////////////////////

   // track host operand until a command starts, then hold it
   always_ff @(posedge clk) begin
      if (state == stIdle) sumOpQ <= sumOperand;
   end

   always_comb begin
      case (state)
         stSig1Hi, stSig1Lo: srcWord = tapM2;
         stSig0Hi, stSig0Lo: srcWord = tapM15;
         default:            srcWord = sumOpQ;
      endcase
   end

   // low word first for the low-half passes
   assign opA = swapHalves ? srcWord[31:0]  : srcWord[63:32];
   assign opB = swapHalves ? srcWord[63:32] : srcWord[31:0];

   //////////////////////////////////////////////////////////////////////
   // half result capture
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (capHi) begin
         case (state)
            stSig1Hi: sig1Q[63:32] <= halfResult;
            stSig0Hi: sig0Q[63:32] <= halfResult;
            stSumHi:  sumQ[63:32]  <= halfResult;
            default: ;
         endcase
      end
      if (capLo) begin
         case (state)
            stSig1Lo: sig1Q[31:0] <= halfResult;
            stSig0Lo: sig0Q[31:0] <= halfResult;
            stSumLo:  sumQ[31:0]  <= halfResult;
            default: ;
         endcase
      end
   end

   // W[t], carries wrap mod 2^64
   assign newWord = sig1Q + tapM7 + sig0Q + tapM16;

   // result source picked by the first pass of the command
   always_ff @(posedge clk) begin
      if (!rstN) begin
         sumMode <= 1'b0;
         result  <= '0;
      end else begin
         if (state == stSumHi) sumMode <= 1'b1;
         else if (state == stSig1Hi) sumMode <= 1'b0;
         if (finish) result <= sumMode ? sumQ : newWord;
      end
   end

endmodule

/* hw/windowPtrCounter.sv */
`timescale 1ns/1ps

module windowPtrCounter import zknhPkg::*; #(
   parameter  int WINDOW_DEPTH = 16,
   localparam int PTR_W        = $clog2(WINDOW_DEPTH)
) (
   input  logic             clk,
   input  logic             rstN,
   input  logic             loadValid,
   input  logic             busy,
   input  logic             writeNew,
   output logic [PTR_W-1:0] ptr,
   output wordIdxT          wordIndex,
   output logic             windowReady
);

   logic advance;

   // host load outside a command, or expansion write-back
   assign advance = (loadValid && !busy) || writeNew;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         ptr         <= '0;
         wordIndex   <= '0;
         windowReady <= 1'b0;
      end else if (advance) begin
         // circular, wraps at depth
         ptr <= (ptr == PTR_W'(WINDOW_DEPTH - 1)) ? '0 : ptr + 1'b1;
         // saturate at W[79]
         if (wordIndex != LAST_WORD_IDX) begin
            wordIndex <= wordIndex + 1'b1;
         end
         // this write fills the last empty slot
         if (wordIndex == wordIdxT'(WINDOW_DEPTH - 1)) begin
            windowReady <= 1'b1;
         end
      end
   end

endmodule

/* hw/zknhPkg.sv */
package zknhPkg;

   //////////////////////////////////////////////////////////////////////
   // word types
   //////////////////////////////////////////////////////////////////////

   // one rv32 register, half of a sha-512 word
   typedef logic [31:0] halfWordT;
   // full schedule or sigma word
   typedef logic [63:0] fullWordT;
   // schedule index W[0] .. W[79]
   typedef logic [6:0]  wordIdxT;

   // index stops counting here
   localparam wordIdxT LAST_WORD_IDX = 7'd79;

   //////////////////////////////////////////////////////////////////////
   // encodings
   //////////////////////////////////////////////////////////////////////

   // zknh rv32 half-ops, value is the xor6 select index
   typedef enum logic [2:0] {
      opSig0h = 3'd0,
      opSig0l = 3'd1,
      opSig1h = 3'd2,
      opSig1l = 3'd3,
      opSum0r = 3'd4,
      opSum1r = 3'd5
   } halfOpT;

   // host commands
   typedef enum logic [1:0] {
      cmdExpand = 2'd0,
      cmdSum0   = 2'd1,
      cmdSum1   = 2'd2
   } cmdT;

   // sequencer states, one half-op pass per state
   typedef enum logic [2:0] {
      stIdle, stSig1Hi, stSig1Lo, stSig0Hi, stSig0Lo, stWrite, stSumHi, stSumLo
   } seqStateT;

endpackage

/* hw/zknhSchedTop.sv */
`timescale 1ns/1ps

module zknhSchedTop import zknhPkg::*; #(
   parameter  int WINDOW_DEPTH = 16,
   localparam int PTR_W        = $clog2(WINDOW_DEPTH)
) (
   input  logic     clk,
   input  logic     rstN,
   input  logic     loadValid,
   input  fullWordT loadWord,
   input  logic     start,
   input  cmdT      cmd,
   input  fullWordT sumOperand,
   output logic     busy,
   output logic     done,
   output fullWordT result,
   output wordIdxT  wordIndex
);

   // sequencer controls
   seqStateT seqState;
   halfOpT   halfSel;
   logic     swapHalves;
   logic     capHi;
   logic     capLo;
   logic     writeNew;
   logic     finish;

   // window side
   logic [PTR_W-1:0] ptr;
   logic             windowReady;
   fullWordT         tapM16;
   fullWordT         tapM15;
   fullWordT         tapM7;
   fullWordT         tapM2;
   fullWordT         newWord;

   // half-op datapath
   halfWordT opA;
   halfWordT opB;
   halfWordT halfResult;

   //////////////////////////////////////////////////////////////////////
   // control
   //////////////////////////////////////////////////////////////////////

   zknhSeqFsm seqFsm_inst (
      .clk, .rstN, .start, .cmd, .windowReady,
      .state(seqState), .halfSel, .swapHalves, .capHi, .capLo,
      .writeNew, .finish, .busy, .done
   );

   windowPtrCounter #(.WINDOW_DEPTH(WINDOW_DEPTH)) ptrCounter_inst (
      .clk, .rstN, .loadValid, .busy, .writeNew, .ptr, .wordIndex, .windowReady
   );

   //////////////////////////////////////////////////////////////////////
   // datapath
   //////////////////////////////////////////////////////////////////////

   scheduleWindow #(.WINDOW_DEPTH(WINDOW_DEPTH)) window_inst (
      .clk, .loadValid, .busy, .loadWord, .writeNew, .newWord, .ptr,
      .tapM16, .tapM15, .tapM7, .tapM2
   );

   sigmaAccum accum_inst (
      .clk, .rstN, .state(seqState), .tapM15, .tapM2, .tapM7, .tapM16,
      .sumOperand, .halfResult, .swapHalves, .capHi, .capLo, .finish,
      .opA, .opB, .newWord, .result
   );

   // one rv32 half-op per cycle
   sha512Half half_inst (
      .A(opA), .B(opB), .ZKNHSelect(halfSel), .result(halfResult)
   );

endmodule

/* hw/zknhSeqFsm.sv */
`timescale 1ns/1ps

module zknhSeqFsm import zknhPkg::*; (
   input  logic     clk,
   input  logic     rstN,
   input  logic     start,
   input  cmdT      cmd,
   input  logic     windowReady,
   output seqStateT state,
   output halfOpT   halfSel,
   output logic     swapHalves,
   output logic     capHi,
   output logic     capLo,
   output logic     writeNew,
   output logic     finish,
   output logic     busy,
   output logic     done
);

   seqStateT stateNext;
   cmdT      cmdQ;
   logic     accept;
   halfOpT   sumSel;

   //////////////////////////////////////////////////////////////////////
   // command accept and state register
   //////////////////////////////////////////////////////////////////////

   // expand needs a full window, sums always go
   assign accept = start && (state == stIdle) &&
                   (((cmd == cmdExpand) && windowReady) ||
                    (cmd == cmdSum0) || (cmd == cmdSum1));

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= stIdle;
         cmdQ  <= cmdExpand;
         done  <= 1'b0;
      end else begin
         state <= stateNext;
         // pulse in the cycle after the write-back state
         done  <= (state == stWrite);
         if (accept) cmdQ <= cmd;
      end
   end

   always_comb begin
      stateNext = state;
      case (state)
         stIdle: begin
            if (accept) stateNext = (cmd == cmdExpand) ? stSig1Hi : stSumHi;
         end
         // expand: sigma1 of W[t-2], then sigma0 of W[t-15]
         stSig1Hi: stateNext = stSig1Lo;
         stSig1Lo: stateNext = stSig0Hi;
         stSig0Hi: stateNext = stSig0Lo;
         stSig0Lo: stateNext = stWrite;
         // sum passes share the write-back state
         stSumHi:  stateNext = stSumLo;
         stSumLo:  stateNext = stWrite;
         stWrite:  stateNext = stIdle;
         default:  stateNext = stIdle;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // per-state decode
   //////////////////////////////////////////////////////////////////////

   assign sumSel = (cmdQ == cmdSum1) ? opSum1r : opSum0r;

   always_comb begin
      halfSel    = opSig0h;
      swapHalves = 1'b0;
      capHi      = 1'b0;
      capLo      = 1'b0;
      case (state)
         stSig1Hi: begin halfSel = opSig1h; capHi = 1'b1; end
         stSig1Lo: begin halfSel = opSig1l; capLo = 1'b1; swapHalves = 1'b1; end
         stSig0Hi: begin halfSel = opSig0h; capHi = 1'b1; end
         stSig0Lo: begin halfSel = opSig0l; capLo = 1'b1; swapHalves = 1'b1; end
         // same op twice, low word goes in as A for the low half
         stSumHi:  begin halfSel = sumSel;  capHi = 1'b1; end
         stSumLo:  begin halfSel = sumSel;  capLo = 1'b1; swapHalves = 1'b1; end
         default: ;
      endcase
   end

   assign finish   = (state == stWrite);
   // window only written back for an expand
   assign writeNew = (state == stWrite) && (cmdQ == cmdExpand);
   assign busy     = (state != stIdle);

endmodule

/* project.f */
hw/zknhPkg.sv
hw/sha512Half.sv
hw/zknhSeqFsm.sv
hw/windowPtrCounter.sv
hw/scheduleWindow.sv
hw/sigmaAccum.sv
hw/zknhSchedTop.sv
bench/zknhSched_sva.sv
bench/zknhSchedTb.sv
